/* vlog.f */
+incdir+rtl
rtl/alu_pkg.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/alu_4bit.sv
rtl/writeback.sv
rtl/alu_core_top.sv
tb/tb_alu_core.sv

/* Makefile */
SRCS := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_alu_core: vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module tb_alu_core \
		-Mdir obj_dir -o Vtb_alu_core

run: obj_dir/Vtb_alu_core
	./obj_dir/Vtb_alu_core | tee sim.log
	grep -qx '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/tb_alu_core.sv */
// testbench for alu_core_top; applies an instruction table back to back and checks every result
`timescale 1ns/1ps

module tb_alu_core;

	localparam int N_ROWS = 23;
	// cycles a result may take before the run is abandoned
	localparam int WAIT_LIMIT = 20;

	logic               clk;
	logic               rst_n;
	logic               in_valid;
	alu_pkg::alu_op_e   in_op;
	alu_pkg::reg_addr_t in_dst;
	alu_pkg::reg_addr_t in_src_a;
	alu_pkg::reg_addr_t in_src_b;
	logic               in_use_imm;
	alu_pkg::data_t     in_imm;
	logic               out_valid;
	alu_pkg::reg_addr_t out_dst;
	alu_pkg::data_t     out_res;
	logic               out_zero;
	logic               out_carry;
	logic               out_overflow;

	// instruction table with expected results
	alu_pkg::alu_op_e   t_op    [N_ROWS];
	alu_pkg::reg_addr_t t_dst   [N_ROWS];
	alu_pkg::reg_addr_t t_src_a [N_ROWS];
	alu_pkg::reg_addr_t t_src_b [N_ROWS];
	logic               t_imm_sel [N_ROWS];
	alu_pkg::data_t     t_imm   [N_ROWS];
	alu_pkg::data_t     t_res   [N_ROWS];
	logic               t_zero  [N_ROWS];
	logic               t_carry [N_ROWS];
	logic               t_ovf   [N_ROWS];

	int issue_cyc [N_ROWS];
	int cycle_cnt = 0;
	int err_cnt = 0;
	int row_errs = 0;
	int strobe_cnt = 0;
	int rows_done = 0;
	logic timed_out = 1'b0;

	alu_core_top dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_op        (in_op),
		.in_dst       (in_dst),
		.in_src_a     (in_src_a),
		.in_src_b     (in_src_b),
		.in_use_imm   (in_use_imm),
		.in_imm       (in_imm),
		.out_valid    (out_valid),
		.out_dst      (out_dst),
		.out_res      (out_res),
		.out_zero     (out_zero),
		.out_carry    (out_carry),
		.out_overflow (out_overflow)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic check_value(input string name, input int row, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] row %0d %s: got 0x%0h, expected 0x%0h", row, name, got, exp);
			err_cnt++;
			row_errs++;
		end
	endtask

	task automatic set_row(input int idx, input alu_pkg::alu_op_e op,
			input alu_pkg::reg_addr_t dst, input alu_pkg::reg_addr_t sa,
			input alu_pkg::reg_addr_t sb, input logic sel, input alu_pkg::data_t imm,
			input alu_pkg::data_t res, input logic z, input logic c, input logic v);
		t_op[idx]      = op;
		t_dst[idx]     = dst;
		t_src_a[idx]   = sa;
		t_src_b[idx]   = sb;
		t_imm_sel[idx] = sel;
		t_imm[idx]     = imm;
		t_res[idx]     = res;
		t_zero[idx]    = z;
		t_carry[idx]   = c;
		t_ovf[idx]     = v;
	endtask

	// columns: row, op, dst, src a, src b, imm select, imm, result, zero, carry, overflow
	task automatic fill_table();
		// unwritten registers read zero, then loads through r0
		set_row(0, alu_pkg::OP_OR, 2'd1, 2'd3, 2'd2, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0);
		set_row(1, alu_pkg::OP_OR, 2'd0, 2'd0, 2'd0, 1'b1, 4'h5, 4'h5, 1'b0, 1'b0, 1'b0);
		set_row(2, alu_pkg::OP_ADD, 2'd1, 2'd0, 2'd0, 1'b0, 4'h0, 4'h0, 1'b1, 1'b0, 1'b0);
		set_row(3, alu_pkg::OP_ADD, 2'd2, 2'd0, 2'd0, 1'b1, 4'h6, 4'h6, 1'b0, 1'b0, 1'b0);
		set_row(4, alu_pkg::OP_OR, 2'd1, 2'd0, 2'd0, 1'b1, 4'h7, 4'h7, 1'b0, 1'b0, 1'b0);
		set_row(5, alu_pkg::OP_OR, 2'd2, 2'd0, 2'd0, 1'b1, 4'h1, 4'h1, 1'b0, 1'b0, 1'b0);
		// 7+1 overflows into the sign bit
		set_row(6, alu_pkg::OP_ADD, 2'd1, 2'd1, 2'd2, 1'b0, 4'h0, 4'h8, 1'b0, 1'b0, 1'b1);
		set_row(7, alu_pkg::OP_OR, 2'd3, 2'd0, 2'd0, 1'b1, 4'h8, 4'h8, 1'b0, 1'b0, 1'b0);
		// 8-1, signed overflow with no borrow
		set_row(8, alu_pkg::OP_SUB, 2'd2, 2'd3, 2'd0, 1'b1, 4'h1, 4'h7, 1'b0, 1'b1, 1'b1);
		set_row(9, alu_pkg::OP_OR, 2'd3, 2'd0, 2'd0, 1'b1, 4'h5, 4'h5, 1'b0, 1'b0, 1'b0);
		set_row(10, alu_pkg::OP_SUB, 2'd3, 2'd3, 2'd0, 1'b1, 4'h5, 4'h0, 1'b1, 1'b1, 1'b0);
		set_row(11, alu_pkg::OP_OR, 2'd1, 2'd0, 2'd0, 1'b1, 4'h2, 4'h2, 1'b0, 1'b0, 1'b0);
		// 2-3 borrows
		set_row(12, alu_pkg::OP_SUB, 2'd2, 2'd1, 2'd0, 1'b1, 4'h3, 4'hf, 1'b0, 1'b0, 1'b0);
		set_row(13, alu_pkg::OP_ADD, 2'd3, 2'd2, 2'd1, 1'b0, 4'h0, 4'h1, 1'b0, 1'b1, 1'b0);
		set_row(14, alu_pkg::OP_NOT, 2'd1, 2'd2, 2'd0, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0);
		set_row(15, alu_pkg::OP_OR, 2'd1, 2'd0, 2'd0, 1'b1, 4'hc, 4'hc, 1'b0, 1'b0, 1'b0);
		set_row(16, alu_pkg::OP_AND, 2'd2, 2'd1, 2'd0, 1'b1, 4'ha, 4'h8, 1'b0, 1'b0, 1'b0);
		set_row(17, alu_pkg::OP_OR, 2'd3, 2'd1, 2'd2, 1'b0, 4'h0, 4'hc, 1'b0, 1'b0, 1'b0);
		set_row(18, alu_pkg::OP_XOR, 2'd1, 2'd3, 2'd0, 1'b1, 4'h5, 4'h9, 1'b0, 1'b0, 1'b0);
		set_row(19, alu_pkg::OP_LT, 2'd2, 2'd3, 2'd1, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0);
		set_row(20, alu_pkg::OP_LT, 2'd2, 2'd1, 2'd3, 1'b0, 4'h0, 4'h1, 1'b0, 1'b0, 1'b0);
		set_row(21, alu_pkg::OP_EQ, 2'd3, 2'd2, 2'd0, 1'b1, 4'h1, 4'h1, 1'b0, 1'b0, 1'b0);
		set_row(22, alu_pkg::OP_EQ, 2'd1, 2'd1, 2'd3, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0);
	endtask

	initial begin : main
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_op      = alu_pkg::OP_ADD;
		in_dst     = '0;
		in_src_a   = '0;
		in_src_b   = '0;
		in_use_imm = 1'b0;
		in_imm     = '0;
		fill_table();

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// pipe must stay quiet with no instruction
		repeat (3) begin
			@(negedge clk);
			check_value("out_valid", -1, 32'(out_valid), 32'd0);
		end

		fork
			begin : drive
				for (int i = 0; i < N_ROWS; i++) begin
					@(negedge clk);
					in_valid     = 1'b1;
					in_op        = t_op[i];
					in_dst       = t_dst[i];
					in_src_a     = t_src_a[i];
					in_src_b     = t_src_b[i];
					in_use_imm   = t_imm_sel[i];
					in_imm       = t_imm[i];
					issue_cyc[i] = cycle_cnt;
				end
				@(negedge clk);
				in_valid = 1'b0;
			end
			begin : collect
				int waited;
				for (int i = 0; i < N_ROWS; i++) begin
					@(negedge clk);
					waited = 1;
					while (!out_valid && waited < WAIT_LIMIT) begin
						@(negedge clk);
						waited++;
					end
					if (!out_valid) begin
						$display("timeout: no result strobe for row %0d", i);
						timed_out = 1'b1;
						break;
					end
					strobe_cnt++;
					row_errs = 0;
					check_value("latency", i, 32'(cycle_cnt - issue_cyc[i]), 32'd2);
					check_value("out_dst", i, 32'(out_dst), 32'(t_dst[i]));
					check_value("out_res", i, 32'(out_res), 32'(t_res[i]));
					check_value("out_zero", i, 32'(out_zero), 32'(t_zero[i]));
					check_value("out_carry", i, 32'(out_carry), 32'(t_carry[i]));
					check_value("out_overflow", i, 32'(out_overflow), 32'(t_ovf[i]));
					if (row_errs == 0) begin
						$display("row %0d %s r%0d = 0x%h ok", i, t_op[i].name(), t_dst[i],
							t_res[i]);
					end else begin
						$display("row %0d %s failed with %0d mismatches", i, t_op[i].name(),
							row_errs);
					end
					rows_done++;
				end
				// any strobe after the last row is one too many
				if (!timed_out) begin
					repeat (4) begin
						@(negedge clk);
						if (out_valid) begin
							strobe_cnt++;
						end
					end
				end
			end
		join

		check_value("strobe count", -1, 32'(strobe_cnt), 32'(N_ROWS));
		$display("rows checked %0d, strobes %0d, errors %0d", rows_done, strobe_cnt, err_cnt);
		if (err_cnt == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* rtl/alu_core_top.sv */
// top of the 4-bit execution core; decode, register file, ALU and writeback in a two-cycle pipe
`timescale 1ns/1ps

module alu_core_top (
	input  logic               clk,
	input  logic               rst_n,
	// instruction strobe
	input  logic               in_valid,
	input  alu_pkg::alu_op_e   in_op,
	input  alu_pkg::reg_addr_t in_dst,
	input  alu_pkg::reg_addr_t in_src_a,
	input  alu_pkg::reg_addr_t in_src_b,
	input  logic               in_use_imm,
	input  alu_pkg::data_t     in_imm,
	// result strobe, two cycles after the instruction
	output logic               out_valid,
	output alu_pkg::reg_addr_t out_dst,
	output alu_pkg::data_t     out_res,
	output logic               out_zero,
	output logic               out_carry,
	output logic               out_overflow
);

	// register file reads
	alu_pkg::reg_addr_t rd_addr_a;
	alu_pkg::reg_addr_t rd_addr_b;
	alu_pkg::data_t     rd_data_a;
	alu_pkg::data_t     rd_data_b;

	// execute stage
	logic               ex_valid;
	alu_pkg::alu_op_e   ex_op;
	alu_pkg::reg_addr_t ex_dst;
	alu_pkg::data_t     ex_a;
	alu_pkg::data_t     ex_b;

	// ALU outputs
	alu_pkg::data_t     alu_res;
	logic               alu_zero;
	logic               alu_carry;
	logic               alu_overflow;

	// write port, shared by the register file and the decode bypass
	logic               wr_en;
	alu_pkg::reg_addr_t wr_addr;
	alu_pkg::data_t     wr_data;

	instr_decode u_decode (
		.clk        (clk),        .rst_n      (rst_n),
		.in_valid   (in_valid),   .in_op      (in_op),
		.in_dst     (in_dst),     .in_src_a   (in_src_a),
		.in_src_b   (in_src_b),   .in_use_imm (in_use_imm),
		.in_imm     (in_imm),
		.rd_addr_a  (rd_addr_a),  .rd_data_a  (rd_data_a),
		.rd_addr_b  (rd_addr_b),  .rd_data_b  (rd_data_b),
		.wr_en      (wr_en),      .wr_addr    (wr_addr),     .wr_data (wr_data),
		.ex_valid   (ex_valid),   .ex_op      (ex_op),       .ex_dst  (ex_dst),
		.ex_a       (ex_a),       .ex_b       (ex_b)
	);

	reg_file u_regs (
		.clk       (clk),       .rst_n     (rst_n),
		.rd_addr_a (rd_addr_a), .rd_data_a (rd_data_a),
		.rd_addr_b (rd_addr_b), .rd_data_b (rd_data_b),
		.wr_en     (wr_en),     .wr_addr   (wr_addr),   .wr_data (wr_data)
	);

	alu_4bit u_alu (
		.alu_fnselec  (ex_op),
		.alu_a        (ex_a),
		.alu_b        (ex_b),
		.alu_res      (alu_res),
		.alu_zero     (alu_zero),
		.alu_carry    (alu_carry),
		.alu_overflow (alu_overflow)
	);

	writeback u_wb (
		.clk          (clk),          .rst_n     (rst_n),
		.ex_valid     (ex_valid),     .ex_dst    (ex_dst),
		.alu_res      (alu_res),      .alu_zero  (alu_zero),
		.alu_carry    (alu_carry),    .alu_overflow (alu_overflow),
		.wr_en        (wr_en),        .wr_addr   (wr_addr),   .wr_data (wr_data),
		.out_valid    (out_valid),    .out_dst   (out_dst),   .out_res (out_res),
		.out_zero     (out_zero),     .out_carry (out_carry),
		.out_overflow (out_overflow)
	);

endmodule

/* rtl/writeback.sv */
// writeback stage; registers the ALU result and flags, drives the register write and result strobe
`timescale 1ns/1ps

module writeback (
	input  logic               clk,
	input  logic               rst_n,
	// instruction in the execute stage
	input  logic               ex_valid,
	input  alu_pkg::reg_addr_t ex_dst,
	// ALU outputs for that instruction
	input  alu_pkg::data_t     alu_res,
	input  logic               alu_zero,
	input  logic               alu_carry,
	input  logic               alu_overflow,
	// write port, also the bypass source for decode
	output logic               wr_en,
	output alu_pkg::reg_addr_t wr_addr,
	output alu_pkg::data_t     wr_data,
	// result strobe to outside
	output logic               out_valid,
	output alu_pkg::reg_addr_t out_dst,
	output alu_pkg::data_t     out_res,
	output logic               out_zero,
	output logic               out_carry,
	output logic               out_overflow
);

	// flags and result keep their value between strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid    <= 1'b0;
			out_dst      <= '0;
			out_res      <= '0;
			out_zero     <= 1'b0;
			out_carry    <= 1'b0;
			out_overflow <= 1'b0;
		end else begin
			out_valid <= ex_valid;
			if (ex_valid) begin
				out_dst      <= ex_dst;
				out_res      <= alu_res;
				out_zero     <= alu_zero;
				out_carry    <= alu_carry;
				out_overflow <= alu_overflow;
			end
		end
	end

	// separate enable flop next to the register file port
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= ex_valid;
		end
	end

	assign wr_addr = out_dst;
	assign wr_data = out_res;

	// an instruction in the stage brings a known destination, result and flags
	a_ex_known: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid |-> !$isunknown({ex_dst, alu_res, alu_zero, alu_carry, alu_overflow}));

endmodule

/* rtl/alu_4bit.sv */
// combinational 4-bit ALU for the core; eight operations with zero, carry and overflow flags
`timescale 1ns/1ps
`include "alu_defs.svh"

//  op   | function
//  000  | a + b
//  001  | a - b
//  010  | not a
//  011  | a and b
//  100  | a or b
//  101  | a xor b
//  110  | 1 if a < b unsigned, else 0
//  111  | 1 if a == b, else 0
//
// flags only mean something for add and subtract, otherwise all zero

module alu_4bit (
	input  alu_pkg::alu_op_e alu_fnselec,
	input  alu_pkg::data_t   alu_a,
	input  alu_pkg::data_t   alu_b,
	output alu_pkg::data_t   alu_res,
	output logic             alu_zero,
	output logic             alu_carry,
	output logic             alu_overflow
);

	// sign bit position
	localparam int MSB = `ALU_W - 1;

	// one extra bit to catch the carry out
	logic [`ALU_W:0] add_sum;
	logic [`ALU_W:0] sub_sum;

	assign add_sum = {1'b0, alu_a} + {1'b0, alu_b};

	// two's complement subtract, carry out set means a >= b
	assign sub_sum = {1'b0, alu_a} + {1'b0, ~alu_b} + (`ALU_W+1)'(1);

	always_comb begin
		alu_res      = '0;
		alu_zero     = 1'b0;
		alu_carry    = 1'b0;
		alu_overflow = 1'b0;

		case (alu_fnselec)
			alu_pkg::OP_ADD: begin
				alu_res   = add_sum[MSB:0];
				alu_carry = add_sum[`ALU_W];
				// like signs in, other sign out
				alu_overflow = (alu_a[MSB] == alu_b[MSB]) &&
					(add_sum[MSB] != alu_a[MSB]);
				alu_zero = (add_sum[MSB:0] == '0);
			end
			alu_pkg::OP_SUB: begin
				alu_res   = sub_sum[MSB:0];
				alu_carry = sub_sum[`ALU_W];
				// signed rule for a - b: operands differ in sign and result flips from a
				alu_overflow = (alu_a[MSB] != alu_b[MSB]) &&
					(sub_sum[MSB] != alu_a[MSB]);
				alu_zero = (sub_sum[MSB:0] == '0);
			end
			alu_pkg::OP_NOT: begin
				alu_res = ~alu_a;
			end
			alu_pkg::OP_AND: begin
				alu_res = alu_a & alu_b;
			end
			alu_pkg::OP_OR: begin
				alu_res = alu_a | alu_b;
			end
			alu_pkg::OP_XOR: begin
				alu_res = alu_a ^ alu_b;
			end
			alu_pkg::OP_LT: begin
				// unsigned compare
				if (alu_a < alu_b) begin
					alu_res = {{(`ALU_W-1){1'b0}}, 1'b1};
				end
			end
			alu_pkg::OP_EQ: begin
				if (alu_a == alu_b) begin
					alu_res = {{(`ALU_W-1){1'b0}}, 1'b1};
				end
			end
			default: begin
				alu_res = '0;
			end
		endcase
	end

endmodule

/* rtl/reg_file.sv */
// four-word register file with two combinational reads, one clocked write and r0 tied to zero
`timescale 1ns/1ps
`include "alu_defs.svh"

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	// read port a
	input  alu_pkg::reg_addr_t rd_addr_a,
	output alu_pkg::data_t     rd_data_a,
	// read port b
	input  alu_pkg::reg_addr_t rd_addr_b,
	output alu_pkg::data_t     rd_data_b,
	// write port from writeback
	input  logic               wr_en,
	input  alu_pkg::reg_addr_t wr_addr,
	input  alu_pkg::data_t     wr_data
);

	alu_pkg::data_t regs [`REG_CNT];

	// r0 is skipped, it holds its reset value of zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// reads see the old value during the write cycle
	always_comb begin
		if (rd_addr_a == '0) begin
			rd_data_a = '0;
		end else begin
			rd_data_a = regs[rd_addr_a];
		end
	end

	always_comb begin
		if (rd_addr_b == '0) begin
			rd_data_b = '0;
		end else begin
			rd_data_b = regs[rd_addr_b];
		end
	end

	// write enable never comes with a floating index
	a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown(wr_addr));

endmodule

/* rtl/instr_decode.sv */
// decode stage; registers each strobed instruction with its operands and bypasses the writeback
`timescale 1ns/1ps

module instr_decode (
	input  logic               clk,
	input  logic               rst_n,
	// instruction strobe from outside
	input  logic               in_valid,
	input  alu_pkg::alu_op_e   in_op,
	input  alu_pkg::reg_addr_t in_dst,
	input  alu_pkg::reg_addr_t in_src_a,
	input  alu_pkg::reg_addr_t in_src_b,
	input  logic               in_use_imm,
	input  alu_pkg::data_t     in_imm,
	// register file read ports
	output alu_pkg::reg_addr_t rd_addr_a,
	input  alu_pkg::data_t     rd_data_a,
	output alu_pkg::reg_addr_t rd_addr_b,
	input  alu_pkg::data_t     rd_data_b,
	// pending write from writeback
	input  logic               wr_en,
	input  alu_pkg::reg_addr_t wr_addr,
	input  alu_pkg::data_t     wr_data,
	// registered instruction towards the ALU and writeback
	output logic               ex_valid,
	output alu_pkg::alu_op_e   ex_op,
	output alu_pkg::reg_addr_t ex_dst,
	output alu_pkg::data_t     ex_a,
	output alu_pkg::data_t     ex_b
);

	// operands as read this cycle, before the stage register
	alu_pkg::data_t     opnd_a;
	alu_pkg::data_t     opnd_b;
	// stage register contents
	alu_pkg::data_t     a_q;
	alu_pkg::data_t     b_q;
	alu_pkg::reg_addr_t src_a_q;
	alu_pkg::reg_addr_t src_b_q;

	assign rd_addr_a = in_src_a;
	assign rd_addr_b = in_src_b;

	// write two instructions ahead lands only at the end of this cycle
	always_comb begin
		opnd_a = rd_data_a;
		if (wr_en && wr_addr == in_src_a && in_src_a != '0) begin
			opnd_a = wr_data;
		end
		opnd_b = rd_data_b;
		if (wr_en && wr_addr == in_src_b && in_src_b != '0) begin
			opnd_b = wr_data;
		end
		if (in_use_imm) begin
			opnd_b = in_imm;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			ex_op   <= in_op;
			ex_dst  <= in_dst;
			a_q     <= opnd_a;
			b_q     <= opnd_b;
			src_a_q <= in_src_a;
			// r0 as source never matches a write, so an immediate is never replaced
			src_b_q <= in_use_imm ? '0 : in_src_b;
		end
	end

	// result of the instruction directly ahead is in writeback now
	always_comb begin
		ex_a = a_q;
		if (wr_en && wr_addr == src_a_q && src_a_q != '0) begin
			ex_a = wr_data;
		end
		ex_b = b_q;
		if (wr_en && wr_addr == src_b_q && src_b_q != '0) begin
			ex_b = wr_data;
		end
	end

	// a strobed instruction carries a real operation
	a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown(in_op));

endmodule

/* rtl/alu_pkg.sv */
// shared types of the execution core; modules refer to them as alu_pkg::name
`include "alu_defs.svh"

package alu_pkg;

	// operation select, same encoding as the original 4-bit ALU
	typedef enum logic [2:0] {
		OP_ADD = 3'b000,
		OP_SUB = 3'b001,
		OP_NOT = 3'b010,
		OP_AND = 3'b011,
		OP_OR  = 3'b100,
		OP_XOR = 3'b101,
		// result is 1 or 0
		OP_LT  = 3'b110,
		OP_EQ  = 3'b111
	} alu_op_e;

	// register index into the file
	typedef logic [`REG_AW-1:0] reg_addr_t;

	// one data word as carried on every operand and result path
	typedef logic [`ALU_W-1:0] data_t;

endpackage

/* rtl/alu_defs.svh */
// width and size macros for the core; include wherever a module or package sizes data
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// data word width in bits
`define ALU_W 4

// entries in the register file, r0 included
`define REG_CNT 4

// bits needed to address one register
// keep in step with REG_CNT
`define REG_AW 2

`endif
